// File: filelist.f
+incdir+design
design/mb_pkg.sv
design/stream_fifo.sv
design/reg_host_port.sv
design/mb_misc_regs.sv
design/pkt_route_table.sv
design/xbar_out_arbiter.sv
design/pkt_crossbar.sv
design/mb_core.sv
sim/tb_mb_core.sv

// File: Makefile
SRCS := $(shell grep -v '^+' filelist.f) design/mb_macros.svh

.PHONY: all run clean

all: run

obj_dir/Vtb_mb_core: filelist.f $(SRCS)
	verilator --binary --timing --assert --top-module tb_mb_core -f filelist.f

run: obj_dir/Vtb_mb_core
	./obj_dir/Vtb_mb_core > sim.log 2>&1; status=$$?; cat sim.log; \
	if [ $$status -ne 0 ] || grep -q "TEST FAILED" sim.log; then exit 1; fi

clean:
	rm -rf obj_dir sim.log

// File: sim/tb_mb_core.sv
/* Core testbench */
`timescale 1ns/1ps
`include "mb_macros.svh"

module tb_mb_core;
  import mb_pkg::*;

  localparam int NP         = `MB_NUM_PORTS;
  localparam int CW         = 72;     // compare width, fits a whole beat
  localparam int REG_LIMIT  = 64;     // cycles for one register handshake
  localparam int XFER_LIMIT = 20000;
  localparam int PKT_COUNT  = 12;     // packets per input

  logic                bus_clk;
  logic                bus_rst;
  logic                i_req_valid;
  logic                o_req_ready;
  reg_req_t            i_req;
  logic                o_rsp_valid;
  logic                i_rsp_ready;
  reg_rsp_t            o_rsp;
  axis_beat_t [NP-1:0] i_in_beat;
  logic [NP-1:0]       i_in_valid;
  logic [NP-1:0]       o_in_ready;
  axis_beat_t [NP-1:0] o_out_beat;
  logic [NP-1:0]       o_out_valid;
  logic [NP-1:0]       i_out_ready;
  logic                i_ref_clk_locked;
  logic                i_meas_clk_locked;
  logic [1:0]          o_pps_select;
  logic                o_pps_out_enb;
  logic                o_ref_clk_reset;
  logic                o_meas_clk_reset;

  logic [31:0] seed;
  int          err_count;
  int          check_count;
  int          test_count;
  int          err_mark;
  logic [31:0] scratch_m;
  logic [31:0] ctrl_m;
  logic [1:0]  route_m [16];
  axis_beat_t  send_q [NP][$];       // beats still to send, per input
  axis_beat_t  exp_q [NP*NP][$];     // [src*NP + out]
  int          exp_total [NP];

  mb_core u_dut (.*);

  initial begin
    bus_clk = 1'b0;
    forever #4 bus_clk = ~bus_clk;
  end

  function automatic logic [31:0] lcg(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [31:0] next_rand();
    seed = lcg(seed);
    return seed;
  endfunction

  // control readback from the written bits and the lock inputs
  function automatic logic [31:0] ctrl_expect();
    return (ctrl_m & 32'h0000_1113) | (32'(i_ref_clk_locked) << 9) |
           (32'(i_meas_clk_locked) << 13);
  endfunction

  task automatic check_eq(input logic [CW-1:0] got, input logic [CW-1:0] exp,
                          input string what);
    check_count++;
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: %s, got %0h expected %0h", $time, what, got, exp);
      err_count++;
    end
  endtask

  task automatic report_test(input string name);
    test_count++;
    $display("[%0t] %-14s %0d errors", $time, name, err_count - err_mark);
    err_mark = err_count;
  endtask

  //////////////////////////////////////////////////////////////////////
  // register port
  //////////////////////////////////////////////////////////////////////
  task automatic reg_access(input logic wr, input logic [13:0] addr,
                            input logic [31:0] wdata, output reg_rsp_t rsp, output int lat);
    int n;
    rsp = '{err: 1'b1, rdata: '1};
    lat = -1;
    i_req_valid <= 1'b1;
    i_req       <= '{wr: wr, addr: addr, wdata: wdata};
    n = 0;
    do begin
      @(posedge bus_clk);
      n++;
    end while (!o_req_ready && n < REG_LIMIT);
    i_req_valid <= 1'b0;
    if (!o_req_ready) begin
      $display("register request to %0h was never accepted", addr);
      err_count++;
      return;
    end
    n = 0;
    do begin
      @(posedge bus_clk);
      n++;
    end while (!o_rsp_valid && n < REG_LIMIT);  // ready held high
    if (!o_rsp_valid) begin
      $display("no register response for address %0h", addr);
      err_count++;
      return;
    end
    rsp = o_rsp;
    lat = n;
  endtask

  task automatic write_reg(input logic [13:0] addr, input logic [31:0] data);
    reg_rsp_t rsp;
    int       lat;
    reg_access(1'b1, addr, data, rsp, lat);
    check_eq(CW'(rsp.err), '0, $sformatf("write error flag at %0h", addr));
    check_eq(CW'(lat), CW'(3), "write response latency");
  endtask

  task automatic read_reg(input logic [13:0] addr, input logic [31:0] exp, input string what);
    reg_rsp_t rsp;
    int       lat;
    reg_access(1'b0, addr, '0, rsp, lat);
    check_eq(CW'(rsp), CW'({1'b0, exp}), what);
    check_eq(CW'(lat), CW'(3), "read response latency");
  endtask

  //////////////////////////////////////////////////////////////////////
  // packet traffic
  //////////////////////////////////////////////////////////////////////
  task automatic build_traffic();
    axis_beat_t  b;
    logic [31:0] r;
    logic [3:0]  dst;
    int          len;
    for (int o = 0; o < NP; o++) exp_total[o] = 0;
    for (int p = 0; p < NP; p++) begin
      for (int k = 0; k < PKT_COUNT; k++) begin
        r   = next_rand();
        len = 1 + int'(r[31:16] % 16'd6);
        dst = r[27:24];
        for (int j = 0; j < len; j++) begin
          b.data = {next_rand(), next_rand()};
          if (j == 0) b.data[7:0] = {4'(p), dst};  // source tag above the dest
          b.last = (j == len - 1);
          send_q[p].push_back(b);
          exp_q[p*NP + int'(route_m[dst])].push_back(b);
          exp_total[route_m[dst]]++;
        end
      end
    end
  endtask

  task automatic drive_input(input int p);
    logic [31:0] st;
    int          n;
    st = lcg(seed + 32'(p));
    while (send_q[p].size() > 0) begin
      st = lcg(st);
      if (st[31:30] == 2'b00) begin
        i_in_valid[p] <= 1'b0;  // idle gap
        @(posedge bus_clk);
      end else begin
        i_in_valid[p] <= 1'b1;
        i_in_beat[p]  <= send_q[p][0];
        n = 0;
        do begin
          @(posedge bus_clk);
          n++;
        end while (!o_in_ready[p] && n < XFER_LIMIT);
        if (!o_in_ready[p]) begin
          $display("input %0d stalled, a beat was never accepted", p);
          err_count++;
          send_q[p].delete();
        end else begin
          void'(send_q[p].pop_front());
        end
      end
    end
    i_in_valid[p] <= 1'b0;
  endtask

  task automatic collect_output(input int o);
    logic [31:0] st;
    logic        in_pkt;
    int          got;
    int          cycles;
    int          src;
    int          q;
    axis_beat_t  exp_b;
    st     = lcg(seed + 32'(NP + o));
    in_pkt = 1'b0;
    got    = 0;
    cycles = 0;
    src    = 0;
    while (got < exp_total[o] && cycles < XFER_LIMIT) begin
      @(posedge bus_clk);
      cycles++;
      if (o_out_valid[o] && i_out_ready[o]) begin
        if (!in_pkt) src = int'(o_out_beat[o].data[5:4]);
        q = src*NP + o;
        check_eq(CW'(exp_q[q].size() > 0), CW'(1),
                 $sformatf("output %0d has a packet pending from input %0d", o, src));
        if (exp_q[q].size() > 0) begin
          exp_b = exp_q[q].pop_front();
          check_eq(CW'(o_out_beat[o]), CW'(exp_b),
                   $sformatf("output %0d beat from input %0d", o, src));
        end
        in_pkt = !o_out_beat[o].last;
        got++;
      end
      st = lcg(st);
      i_out_ready[o] <= (st[31:30] != 2'b00);  // random back-pressure
    end
    if (got < exp_total[o]) begin
      $display("output %0d timed out with %0d of %0d beats", o, got, exp_total[o]);
      err_count++;
    end
    i_out_ready[o] <= 1'b1;
  endtask

  initial begin
    logic [31:0] r;
    reg_rsp_t    rsp;
    int          lat;
    int          n;
    seed        = 32'h7d1a_5884;
    err_count   = 0;
    check_count = 0;
    test_count  = 0;
    err_mark    = 0;
    scratch_m   = '0;
    ctrl_m      = 32'h0000_0001;
    for (int d = 0; d < 16; d++) route_m[d] = 2'(d % NP);
    i_req_valid       <= 1'b0;
    i_req             <= '0;
    i_rsp_ready       <= 1'b1;
    i_in_beat         <= '0;
    i_in_valid        <= '0;
    i_out_ready       <= '1;
    i_ref_clk_locked  <= 1'b1;
    i_meas_clk_locked <= 1'b0;
    bus_rst           <= 1'b1;
    repeat (3) @(posedge bus_clk);
    bus_rst <= 1'b0;
    @(posedge bus_clk);

    // reset values, then identity registers
    check_eq(CW'({o_pps_select, o_pps_out_enb, o_ref_clk_reset, o_meas_clk_reset}),
             CW'(5'b01000), "clock control outputs after reset");
    check_eq(CW'({o_req_ready, o_rsp_valid, o_out_valid}), CW'(6'b100000),
             "handshake outputs after reset");
    read_reg(`MB_REG_CLOCK_CTRL, ctrl_expect(), "clock control after reset");
    read_reg(`MB_REG_GIT_HASH, `MB_GIT_HASH, "build hash");
    read_reg(`MB_REG_NUM_PORTS, 32'(NP), "port count");
    report_test("reset");

    for (int k = 0; k < 8; k++) begin
      scratch_m = next_rand();
      write_reg(`MB_REG_SCRATCH, scratch_m);
      read_reg(`MB_REG_SCRATCH, scratch_m, "scratch readback");
    end
    report_test("scratch");

    for (int k = 0; k < 6; k++) begin
      r = next_rand();
      write_reg(`MB_REG_CLOCK_CTRL, r);
      ctrl_m = r & 32'h0000_1113;
      check_eq(CW'({o_pps_select, o_pps_out_enb, o_ref_clk_reset, o_meas_clk_reset}),
               CW'({r[1:0], r[4], r[8], r[12]}), "clock control outputs");
      read_reg(`MB_REG_CLOCK_CTRL, ctrl_expect(), "clock control readback");
    end
    for (int k = 0; k < 4; k++) begin
      r = next_rand();
      // each lock flips on alternate rounds, randomly on the others
      i_ref_clk_locked  <= i_ref_clk_locked ^ (r[20] || (k % 2 == 1));
      i_meas_clk_locked <= i_meas_clk_locked ^ (r[21] || (k % 2 == 0));
      n = 0;
      do begin
        reg_access(1'b0, `MB_REG_CLOCK_CTRL, '0, rsp, lat);  // synchronizer delay
        n++;
      end while (rsp.rdata !== ctrl_expect() && n < 8);
      check_eq(CW'(rsp.rdata), CW'(ctrl_expect()), "lock bits in clock control");
    end
    report_test("clock control");

    reg_access(1'b0, 14'h0800, '0, rsp, lat);
    check_eq(CW'(rsp), CW'({1'b1, 32'h0}), "unmapped read response");
    read_reg(`MB_REG_SCRATCH, scratch_m, "scratch after unmapped read");
    report_test("unmapped read");

    for (int d = 0; d < 16; d++) begin
      read_reg(`MB_REG_XBAR_BASE + 14'(4*d), 32'(route_m[d]), "route entry after reset");
    end
    for (int d = 0; d < 16; d++) begin
      r = next_rand();
      route_m[d] = r[1:0];
      write_reg(`MB_REG_XBAR_BASE + 14'(4*d), r);
    end
    for (int d = 0; d < 16; d++) begin
      read_reg(`MB_REG_XBAR_BASE + 14'(4*d), 32'(route_m[d]), "route entry readback");
    end
    report_test("route table");

    build_traffic();
    fork
      drive_input(0);
      drive_input(1);
      drive_input(2);
      drive_input(3);
      collect_output(0);
      collect_output(1);
      collect_output(2);
      collect_output(3);
    join
    for (int q = 0; q < NP*NP; q++) begin
      check_eq(CW'(exp_q[q].size()), '0, $sformatf("beats left in queue %0d", q));
    end
    repeat (16) begin
      @(posedge bus_clk);
      check_eq(CW'(o_out_valid), '0, "output valid after traffic");
    end
    report_test("packet traffic");

    $display("tests %0d, checks %0d, errors %0d", test_count, check_count, err_count);
    if (err_count == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// File: design/mb_core.sv
/* Motherboard bus-clock core */
`timescale 1ns/1ps
`include "mb_macros.svh"

module mb_core (
  input  logic                                    bus_clk,
  input  logic                                    bus_rst,
  input  logic                                    i_req_valid,
  output logic                                    o_req_ready,
  input  mb_pkg::reg_req_t                        i_req,
  output logic                                    o_rsp_valid,
  input  logic                                    i_rsp_ready,
  output mb_pkg::reg_rsp_t                        o_rsp,
  input  mb_pkg::axis_beat_t [`MB_NUM_PORTS-1:0]  i_in_beat,
  input  logic [`MB_NUM_PORTS-1:0]                i_in_valid,
  output logic [`MB_NUM_PORTS-1:0]                o_in_ready,
  output mb_pkg::axis_beat_t [`MB_NUM_PORTS-1:0]  o_out_beat,
  output logic [`MB_NUM_PORTS-1:0]                o_out_valid,
  input  logic [`MB_NUM_PORTS-1:0]                i_out_ready,
  input  logic                                    i_ref_clk_locked,
  input  logic                                    i_meas_clk_locked,
  output logic [1:0]                              o_pps_select,
  output logic                                    o_pps_out_enb,
  output logic                                    o_ref_clk_reset,
  output logic                                    o_meas_clk_reset
);
  import mb_pkg::*;

  reg_strobe_t strobe;      // shared by both register peers
  reg_reply_t  reply_misc;
  reg_reply_t  reply_xbar;

  reg_host_port u_host (
    .bus_clk      (bus_clk),
    .bus_rst      (bus_rst),
    .i_req_valid  (i_req_valid),
    .o_req_ready  (o_req_ready),
    .i_req        (i_req),
    .o_rsp_valid  (o_rsp_valid),
    .i_rsp_ready  (i_rsp_ready),
    .o_rsp        (o_rsp),
    .o_strobe     (strobe),
    .i_reply_misc (reply_misc),
    .i_reply_xbar (reply_xbar)
  );

  mb_misc_regs u_misc (
    .bus_clk           (bus_clk),
    .bus_rst           (bus_rst),
    .i_strobe          (strobe),
    .o_reply           (reply_misc),
    .i_ref_clk_locked  (i_ref_clk_locked),
    .i_meas_clk_locked (i_meas_clk_locked),
    .o_pps_select      (o_pps_select),
    .o_pps_out_enb     (o_pps_out_enb),
    .o_ref_clk_reset   (o_ref_clk_reset),
    .o_meas_clk_reset  (o_meas_clk_reset)
  );

  pkt_crossbar u_xbar (
    .bus_clk     (bus_clk),
    .bus_rst     (bus_rst),
    .i_strobe    (strobe),
    .o_reply     (reply_xbar),
    .i_in_beat   (i_in_beat),
    .i_in_valid  (i_in_valid),
    .o_in_ready  (o_in_ready),
    .o_out_beat  (o_out_beat),
    .o_out_valid (o_out_valid),
    .i_out_ready (i_out_ready)
  );

endmodule

// File: design/pkt_crossbar.sv
/* Packet crossbar */
`timescale 1ns/1ps
`include "mb_macros.svh"

module pkt_crossbar (
  input  logic                                    bus_clk,
  input  logic                                    bus_rst,
  input  mb_pkg::reg_strobe_t                     i_strobe,
  output mb_pkg::reg_reply_t                      o_reply,
  input  mb_pkg::axis_beat_t [`MB_NUM_PORTS-1:0]  i_in_beat,
  input  logic [`MB_NUM_PORTS-1:0]                i_in_valid,
  output logic [`MB_NUM_PORTS-1:0]                o_in_ready,
  output mb_pkg::axis_beat_t [`MB_NUM_PORTS-1:0]  o_out_beat,
  output logic [`MB_NUM_PORTS-1:0]                o_out_valid,
  input  logic [`MB_NUM_PORTS-1:0]                i_out_ready
);
  import mb_pkg::*;

  localparam int N  = `MB_NUM_PORTS;
  localparam int PW = `MB_PORT_W;

  axis_beat_t [N-1:0]           head;
  logic [N-1:0]                 head_valid;
  logic [N-1:0]                 head_pop;
  logic [N-1:0]                 in_pkt_q;     // head is past the header beat
  logic [N-1:0][PW-1:0]         port_q;       // routed port of the open packet
  logic [N-1:0][PW-1:0]         lookup_port;
  logic [N-1:0][PW-1:0]         route_port;
  logic [N-1:0][`MB_DST_W-1:0]  lookup_dst;
  logic [N-1:0][N-1:0]          out_req;      // [output][input]
  logic [N-1:0][N-1:0]          out_pop;

  //////////////////////////////////////////////////////////////////////
  // input side
  //////////////////////////////////////////////////////////////////////
  for (genvar gi = 0; gi < N; gi++) begin : g_in
    stream_fifo #(
      .DEPTH (`MB_IN_FIFO_DEPTH),
      .T     (axis_beat_t)
    ) u_in_fifo (
      .bus_clk (bus_clk),
      .bus_rst (bus_rst),
      .i_valid (i_in_valid[gi]),
      .o_ready (o_in_ready[gi]),
      .i_data  (i_in_beat[gi]),
      .o_valid (head_valid[gi]),
      .i_ready (head_pop[gi]),
      .o_data  (head[gi])
    );

    assign lookup_dst[gi] = head[gi].data[`MB_DST_W-1:0];
    assign route_port[gi] = in_pkt_q[gi] ? port_q[gi] : lookup_port[gi];
  end

  pkt_route_table u_route_table (
    .bus_clk       (bus_clk),
    .bus_rst       (bus_rst),
    .i_strobe      (i_strobe),
    .o_reply       (o_reply),
    .i_lookup_dst  (lookup_dst),
    .o_lookup_port (lookup_port)
  );

  always_comb begin
    out_req  = '0;
    head_pop = '0;
    for (int o = 0; o < N; o++) begin
      for (int i = 0; i < N; i++) begin
        out_req[o][i] = head_valid[i] && (route_port[i] == PW'(o));
        head_pop[i]   = head_pop[i] | out_pop[o][i];
      end
    end
  end

  always_ff @(posedge bus_clk) begin
    if (bus_rst) begin
      in_pkt_q <= '0;
    end else begin
      for (int i = 0; i < N; i++) begin
        if (head_pop[i]) in_pkt_q[i] <= !head[i].last;
      end
    end
  end

  // hold the header's route for the rest of the packet
  always_ff @(posedge bus_clk) begin
    for (int i = 0; i < N; i++) begin
      if (head_pop[i] && !in_pkt_q[i]) port_q[i] <= lookup_port[i];
    end
  end

  //////////////////////////////////////////////////////////////////////
  // output side
  //////////////////////////////////////////////////////////////////////
  for (genvar go = 0; go < N; go++) begin : g_out
    xbar_out_arbiter u_arb (
      .bus_clk   (bus_clk),
      .bus_rst   (bus_rst),
      .i_request (out_req[go]),
      .i_beat    (head),
      .i_valid   (head_valid),
      .o_pop     (out_pop[go]),
      .o_beat    (o_out_beat[go]),
      .o_valid   (o_out_valid[go]),
      .i_ready   (i_out_ready[go])
    );
  end

endmodule

// File: design/xbar_out_arbiter.sv
/* Round-robin packet arbiter */
`timescale 1ns/1ps
`include "mb_macros.svh"

module xbar_out_arbiter (
  input  logic                                    bus_clk,
  input  logic                                    bus_rst,
  input  logic [`MB_NUM_PORTS-1:0]                i_request,
  input  mb_pkg::axis_beat_t [`MB_NUM_PORTS-1:0]  i_beat,
  input  logic [`MB_NUM_PORTS-1:0]                i_valid,
  output logic [`MB_NUM_PORTS-1:0]                o_pop,
  output mb_pkg::axis_beat_t                      o_beat,
  output logic                                    o_valid,
  input  logic                                    i_ready
);

  localparam int N  = `MB_NUM_PORTS;
  localparam int PW = `MB_PORT_W;

  logic          locked_q;  // a packet owns this output
  logic [PW-1:0] grant_q;   // current or last granted input
  logic [PW-1:0] pick;
  logic          found;
  logic          accept;

  // search starts just after the last grant
  always_comb begin
    pick  = grant_q;
    found = 1'b0;
    for (int k = 1; k <= N; k++) begin
      if (!found && i_request[(int'(grant_q) + k) % N]) begin
        pick  = PW'((int'(grant_q) + k) % N);
        found = 1'b1;
      end
    end
  end

  assign o_valid = locked_q && i_valid[grant_q];
  assign o_beat  = i_beat[grant_q];
  assign accept  = o_valid && i_ready;
  assign o_pop   = accept ? (N'(1) << grant_q) : '0;

  always_ff @(posedge bus_clk) begin
    if (bus_rst) begin
      locked_q <= 1'b0;
      grant_q  <= PW'(N - 1);  // input 0 wins first
    end else if (!locked_q) begin
      if (found) begin
        locked_q <= 1'b1;
        grant_q  <= pick;
      end
    end else if (accept && o_beat.last) begin
      locked_q <= 1'b0;  // end of packet
    end
  end

  // pops only go to an input whose head is routed here
  assert property (@(posedge bus_clk) disable iff (bus_rst)
    (o_pop != '0) |-> ((o_pop & i_request) == o_pop))
    else $error("arbiter popped an input that does not request this output");

endmodule

// File: design/pkt_route_table.sv
/* Crossbar route table */
`timescale 1ns/1ps
`include "mb_macros.svh"

module pkt_route_table (
  input  logic                                       bus_clk,
  input  logic                                       bus_rst,
  input  mb_pkg::reg_strobe_t                        i_strobe,
  output mb_pkg::reg_reply_t                         o_reply,
  input  logic [`MB_NUM_PORTS-1:0][`MB_DST_W-1:0]    i_lookup_dst,
  output logic [`MB_NUM_PORTS-1:0][`MB_PORT_W-1:0]   o_lookup_port
);

  localparam int                    NUM_DST   = 1 << `MB_DST_W;
  localparam logic [`MB_REG_AW-1:0] SPAN_MASK = `MB_REG_AW'(4 * NUM_DST - 1);

  logic [NUM_DST-1:0][`MB_PORT_W-1:0] route_q;
  logic [`MB_DST_W-1:0]               idx;
  logic                               hit;
  logic                               ack_q;
  logic [`MB_REG_DW-1:0]              data_q;

  assign idx = i_strobe.addr[`MB_DST_W+1:2];
  assign hit = ((i_strobe.addr & ~SPAN_MASK) == `MB_REG_XBAR_BASE) &&
               (i_strobe.addr[1:0] == 2'b00);

  always_ff @(posedge bus_clk) begin
    if (bus_rst) begin
      for (int d = 0; d < NUM_DST; d++) begin
        route_q[d] <= `MB_PORT_W'(d % `MB_NUM_PORTS);  // spread dests over ports
      end
    end else if (i_strobe.wr_stb && hit) begin
      route_q[idx] <= i_strobe.wdata[`MB_PORT_W-1:0];
    end
  end

  always_ff @(posedge bus_clk) begin
    if (bus_rst) ack_q <= 1'b0;
    else         ack_q <= i_strobe.rd_stb && hit;
  end

  always_ff @(posedge bus_clk) begin
    data_q <= (i_strobe.rd_stb && hit) ? `MB_REG_DW'(route_q[idx]) : '0;
  end

  assign o_reply.ack  = ack_q;
  assign o_reply.data = data_q;

  always_comb begin
    for (int i = 0; i < `MB_NUM_PORTS; i++) begin
      o_lookup_port[i] = route_q[i_lookup_dst[i]];
    end
  end

endmodule

// File: design/mb_misc_regs.sv
/* Misc and clock control registers */
`timescale 1ns/1ps
`include "mb_macros.svh"

module mb_misc_regs #(
  parameter logic [`MB_REG_DW-1:0] GIT_HASH = `MB_GIT_HASH
) (
  input  logic                bus_clk,
  input  logic                bus_rst,
  input  mb_pkg::reg_strobe_t i_strobe,
  output mb_pkg::reg_reply_t  o_reply,
  input  logic                i_ref_clk_locked,
  input  logic                i_meas_clk_locked,
  output logic [1:0]          o_pps_select,
  output logic                o_pps_out_enb,
  output logic                o_ref_clk_reset,
  output logic                o_meas_clk_reset
);

  logic [`MB_REG_DW-1:0] scratch_q;
  logic [1:0]            ref_sync_q;   // [1] is the synchronized level
  logic [1:0]            meas_sync_q;
  logic                  rd_hit;
  logic [`MB_REG_DW-1:0] rd_data;
  logic                  ack_q;
  logic [`MB_REG_DW-1:0] data_q;

  //////////////////////////////////////////////////////////////////////
  // lock inputs come from other clock domains
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge bus_clk) begin
    if (bus_rst) begin
      ref_sync_q  <= '0;
      meas_sync_q <= '0;
    end else begin
      ref_sync_q  <= {ref_sync_q[0], i_ref_clk_locked};
      meas_sync_q <= {meas_sync_q[0], i_meas_clk_locked};
    end
  end

  always_ff @(posedge bus_clk) begin
    if (bus_rst) begin
      scratch_q        <= '0;
      o_pps_select     <= 2'b01;  // internal pps by default
      o_pps_out_enb    <= 1'b0;
      o_ref_clk_reset  <= 1'b0;
      o_meas_clk_reset <= 1'b0;
    end else if (i_strobe.wr_stb) begin
      case (i_strobe.addr)
        `MB_REG_SCRATCH: scratch_q <= i_strobe.wdata;
        `MB_REG_CLOCK_CTRL: begin
          o_pps_select     <= i_strobe.wdata[1:0];
          o_pps_out_enb    <= i_strobe.wdata[4];
          o_ref_clk_reset  <= i_strobe.wdata[8];
          o_meas_clk_reset <= i_strobe.wdata[12];
        end
        default: ;  // not ours
      endcase
    end
  end

  always_comb begin
    rd_hit  = 1'b1;
    rd_data = '0;
    case (i_strobe.addr)
      `MB_REG_GIT_HASH:  rd_data = GIT_HASH;
      `MB_REG_NUM_PORTS: rd_data = `MB_REG_DW'(`MB_NUM_PORTS);
      `MB_REG_SCRATCH:   rd_data = scratch_q;
      `MB_REG_CLOCK_CTRL: begin
        rd_data[1:0] = o_pps_select;
        rd_data[4]   = o_pps_out_enb;
        rd_data[8]   = o_ref_clk_reset;
        rd_data[9]   = ref_sync_q[1];
        rd_data[12]  = o_meas_clk_reset;
        rd_data[13]  = meas_sync_q[1];
      end
      default: rd_hit = 1'b0;
    endcase
  end

  always_ff @(posedge bus_clk) begin
    if (bus_rst) ack_q <= 1'b0;
    else         ack_q <= i_strobe.rd_stb && rd_hit;
  end

  // zero unless replying, the host ORs the peers
  always_ff @(posedge bus_clk) begin
    data_q <= (i_strobe.rd_stb && rd_hit) ? rd_data : '0;
  end

  assign o_reply.ack  = ack_q;
  assign o_reply.data = data_q;

endmodule

// File: design/reg_host_port.sv
/* Register host port */
`timescale 1ns/1ps
`include "mb_macros.svh"

module reg_host_port (
  input  logic                bus_clk,
  input  logic                bus_rst,
  input  logic                i_req_valid,
  output logic                o_req_ready,
  input  mb_pkg::reg_req_t    i_req,
  output logic                o_rsp_valid,
  input  logic                i_rsp_ready,
  output mb_pkg::reg_rsp_t    o_rsp,
  output mb_pkg::reg_strobe_t o_strobe,
  input  mb_pkg::reg_reply_t  i_reply_misc,
  input  mb_pkg::reg_reply_t  i_reply_xbar
);
  import mb_pkg::*;

  localparam int TW = $clog2(`MB_REG_TIMEOUT);

  typedef enum logic [1:0] {
    S_IDLE,
    S_WAIT,  // strobe cycle
    S_RESP   // collect reply or count down
  } state_t;

  state_t        state_q;
  reg_req_t      req_q;
  logic [TW-1:0] wait_cnt_q;
  logic          accept;
  logic          any_reply;
  logic          timed_out;
  logic          rsp_push;
  logic          fifo_ready;
  reg_rsp_t      rsp_d;

  assign accept    = i_req_valid && o_req_ready;
  assign any_reply = i_reply_misc.ack | i_reply_xbar.ack;
  assign timed_out = (wait_cnt_q == TW'(`MB_REG_TIMEOUT - 1));
  assign rsp_push  = (state_q == S_RESP) && (req_q.wr || any_reply || timed_out);

  // writes ack right away, reads take the merged peer data
  assign rsp_d.err   = !req_q.wr && !any_reply;
  assign rsp_d.rdata = i_reply_misc.data | i_reply_xbar.data;

  assign o_req_ready = (state_q == S_IDLE) && fifo_ready && !o_rsp_valid;

  assign o_strobe.wr_stb = (state_q == S_WAIT) && req_q.wr;
  assign o_strobe.rd_stb = (state_q == S_WAIT) && !req_q.wr;
  assign o_strobe.addr   = req_q.addr;
  assign o_strobe.wdata  = req_q.wdata;

  always_ff @(posedge bus_clk) begin
    if (accept) req_q <= i_req;
  end

  always_ff @(posedge bus_clk) begin
    if (bus_rst) begin
      state_q    <= S_IDLE;
      wait_cnt_q <= '0;
    end else begin
      case (state_q)
        S_IDLE: begin
          if (accept) state_q <= S_WAIT;
        end
        S_WAIT: begin
          state_q    <= S_RESP;
          wait_cnt_q <= '0;
        end
        S_RESP: begin
          wait_cnt_q <= wait_cnt_q + 1'b1;
          if (rsp_push) state_q <= S_IDLE;
        end
        default: state_q <= S_IDLE;
      endcase
    end
  end

  stream_fifo #(
    .DEPTH (2),
    .T     (reg_rsp_t)
  ) u_rsp_fifo (
    .bus_clk (bus_clk),
    .bus_rst (bus_rst),
    .i_valid (rsp_push),
    .o_ready (fifo_ready),
    .i_data  (rsp_d),
    .o_valid (o_rsp_valid),
    .i_ready (i_rsp_ready),
    .o_data  (o_rsp)
  );

  // peers decode disjoint address ranges
  assert property (@(posedge bus_clk) disable iff (bus_rst)
    !(i_reply_misc.ack && i_reply_xbar.ack))
    else $error("two register peers replied in the same cycle");

endmodule

// File: design/stream_fifo.sv
/* Valid/ready FIFO */
`timescale 1ns/1ps

module stream_fifo #(
  parameter int  DEPTH = 2,
  parameter type T     = logic [7:0]
) (
  input  logic bus_clk,
  input  logic bus_rst,
  input  logic i_valid,
  output logic o_ready,
  input  T     i_data,
  output logic o_valid,
  input  logic i_ready,
  output T     o_data
);

  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  T              mem [DEPTH];
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [AW:0]   count;
  logic          do_wr;
  logic          do_rd;

  assign o_ready = (count < DEPTH);
  assign o_valid = (count != '0);
  assign o_data  = mem[rd_ptr];
  assign do_wr   = i_valid && o_ready;
  assign do_rd   = o_valid && i_ready;

  always_ff @(posedge bus_clk) begin
    if (do_wr) mem[wr_ptr] <= i_data;
  end

  always_ff @(posedge bus_clk) begin
    if (bus_rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr) wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (do_rd) rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // a writer refused while full holds its data
  assert property (@(posedge bus_clk) disable iff (bus_rst)
    (i_valid && !o_ready) |=> (i_valid && $stable(i_data)))
    else $error("stream_fifo input dropped while full");

endmodule

// File: design/mb_pkg.sv
/* Shared bus types */
`include "mb_macros.svh"

package mb_pkg;

  // register request from the host side, 47 bits
  typedef struct packed {
    logic                  wr;
    logic [`MB_REG_AW-1:0] addr;
    logic [`MB_REG_DW-1:0] wdata;
  } reg_req_t;

  // register response back to the host, 33 bits
  typedef struct packed {
    logic                  err;
    logic [`MB_REG_DW-1:0] rdata;
  } reg_rsp_t;

  // strobe from the host port to the register peers, 48 bits
  typedef struct packed {
    logic                  wr_stb;
    logic                  rd_stb;
    logic [`MB_REG_AW-1:0] addr;
    logic [`MB_REG_DW-1:0] wdata;
  } reg_strobe_t;

  // peer read reply, data is zero when ack is low
  typedef struct packed {
    logic                  ack;
    logic [`MB_REG_DW-1:0] data;
  } reg_reply_t;

  // one stream beat, 65 bits
  typedef struct packed {
    logic [`MB_DATA_W-1:0] data;
    logic                  last;
  } axis_beat_t;

endpackage

// File: design/mb_macros.svh
/* Core sizing and register map */
`ifndef MB_MACROS_SVH
`define MB_MACROS_SVH

// crossbar sizing
`define MB_NUM_PORTS      4
`define MB_PORT_W         2
`define MB_DATA_W         64
`define MB_DST_W          4             // low bits of a header beat
`define MB_IN_FIFO_DEPTH  4

// register port
`define MB_REG_AW         14
`define MB_REG_DW         32
`define MB_REG_TIMEOUT    16            // cycles to wait for a read reply
`define MB_GIT_HASH       32'h0c0f_fee5 // default build hash

// register map
`define MB_REG_GIT_HASH   14'h0000
`define MB_REG_NUM_PORTS  14'h0004
`define MB_REG_SCRATCH    14'h0008
`define MB_REG_CLOCK_CTRL 14'h000C
`define MB_REG_XBAR_BASE  14'h1000      // route entry d at base + 4*d

`endif
